/* Bender.yml */
package:
  name: eth_arb_mux

sources:
  # RTL in compile order
  - files:
      - src/eth_arb_pkg.sv
      - src/arbiter.sv
      - src/eth_mux_64_4.sv
      - src/eth_arb_cfg.sv
      - src/eth_arb_mux_64_4.sv
      - src/eth_arb_mux_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - dv/eth_arb_mux_asserts.sv
      - dv/eth_arb_mux_tb.sv

/* dv/eth_arb_mux_asserts.sv */
////////////////////////////////////////////////////////////
// concurrent checks on the arbitrated mux top, bound in
// from the testbench build, failures counted for the tb
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module eth_arb_mux_asserts import eth_arb_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [N_PORTS-1:0] grant,
    input  logic               out_hdr_valid,
    input  logic               out_beat_valid,
    input  logic               out_beat_ready,
    input  eth_beat_t          out_beat
);

    int error_count = 0;                 // read by the testbench at the end

    grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant))
        else begin
            $error("arbiter grant is not one-hot or zero");
            error_count++;
        end

    valids_low_after_reset: assert property (@(posedge clk)
        reset |=> !out_hdr_valid && !out_beat_valid)
        else begin
            $error("output valid high in the cycle after reset");
            error_count++;
        end

    // stalled beat must hold its value
    beat_stable_stalled: assert property (@(posedge clk) disable iff (reset)
        out_beat_valid && !out_beat_ready |=> out_beat_valid && $stable(out_beat))
        else begin
            $error("out_beat changed while stalled");
            error_count++;
        end

endmodule

bind eth_arb_mux_top eth_arb_mux_asserts asserts0 (
    .clk            (clk),
    .reset          (reset),
    .grant          (arb_mux0.grant),
    .out_hdr_valid  (out_hdr_valid),
    .out_beat_valid (out_beat_valid),
    .out_beat_ready (out_beat_ready),
    .out_beat       (out_beat)
);

/* dv/eth_arb_mux_tb.sv */
////////////////////////////////////////////////////////////
// directed testbench for the arbitrated ethernet mux top,
// compiled from sources.f with eth_arb_mux_tb as top
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module eth_arb_mux_tb import eth_arb_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int N_TESTS     = 5;
    localparam int TOTAL_BEATS = 4 + 4 * 3 + 5 * 3 + 2 * 4 + 2 * 16;
    localparam int WATCHDOG_NS = CLK_PERIOD * (TOTAL_BEATS + 50 * N_TESTS) * 4;

    logic clk;
    logic reset;
    logic [N_PORTS-1:0] in_hdr_valid;
    logic [N_PORTS-1:0] in_hdr_ready;
    eth_hdr_t [N_PORTS-1:0] in_hdr;
    logic [N_PORTS-1:0] in_beat_valid;
    logic [N_PORTS-1:0] in_beat_ready;
    eth_beat_t [N_PORTS-1:0] in_beat;
    logic out_hdr_valid;
    logic out_hdr_ready;
    eth_hdr_t out_hdr;
    logic out_beat_valid;
    logic out_beat_ready;
    eth_beat_t out_beat;
    logic cfg_write;
    logic cfg_read;
    cfg_addr_e cfg_addr;
    logic [7:0] cfg_wdata;
    logic [7:0] cfg_rdata;
    logic cfg_rvalid;

    eth_hdr_t exp_hdr_q[$];
    eth_hdr_t got_hdr_q[$];
    eth_beat_t exp_beat_q[$];
    eth_beat_t got_beat_q[$];
    int check_count = 0;
    int err_count = 0;
    logic bp_enable = 1'b0;              // random output stalls on
    logic watch_disabled = 1'b0;         // ports 0 and 2 must stay idle

    eth_arb_mux_top #(.RESET_MODE(ARB_PRIORITY)) dut0 (
        .clk(clk), .reset(reset),
        .in_hdr_valid(in_hdr_valid), .in_hdr_ready(in_hdr_ready), .in_hdr(in_hdr),
        .in_beat_valid(in_beat_valid), .in_beat_ready(in_beat_ready), .in_beat(in_beat),
        .out_hdr_valid(out_hdr_valid), .out_hdr_ready(out_hdr_ready), .out_hdr(out_hdr),
        .out_beat_valid(out_beat_valid), .out_beat_ready(out_beat_ready),
        .out_beat(out_beat),
        .cfg_write(cfg_write), .cfg_read(cfg_read), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata), .cfg_rvalid(cfg_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // header and beat contents encode port, frame and beat index
    function automatic eth_hdr_t make_hdr(input int port, input int frame);
        eth_hdr_t h;
        h.dest_mac = {40'h02_00_5e_10_00, 8'(port)};
        h.src_mac  = {40'h0a_00_27_00_00, 8'(frame)};
        h.eth_type = 16'h0800 + 16'(port * 16 + frame);
        return h;
    endfunction

    function automatic eth_beat_t make_beat(input int port, input int frame,
                                            input int idx, input int n);
        eth_beat_t b;
        b.tdata = {8'(port), 8'(frame), 16'(idx), 32'h5a5a_0000 + 32'(idx * 7)};
        b.tlast = (idx == n - 1);
        b.tkeep = b.tlast ? (8'hff >> ((port + idx) % 8)) : 8'hff;
        b.tuser = b.tlast & frame[0];    // odd frames flag an error
        return b;
    endfunction

    task automatic expect_frame(input int port, input int frame, input int n);
        exp_hdr_q.push_back(make_hdr(port, frame));
        for (int i = 0; i < n; i++) begin
            exp_beat_q.push_back(make_beat(port, frame, i, n));
        end
    endtask

    task automatic drive_hdr(input int port, input eth_hdr_t hdr);
        in_hdr[port]       = hdr;
        in_hdr_valid[port] = 1'b1;
        @(negedge clk);
        while (!in_hdr_ready[port]) @(negedge clk);
        @(posedge clk);
        #2;
        in_hdr_valid[port] = 1'b0;
    endtask

    task automatic drive_beats(input int port, input int frame, input int n);
        for (int i = 0; i < n; i++) begin
            in_beat[port]       = make_beat(port, frame, i, n);
            in_beat_valid[port] = 1'b1;
            @(negedge clk);
            while (!in_beat_ready[port]) @(negedge clk);
            @(posedge clk);
            #2;
        end
        in_beat_valid[port] = 1'b0;
    endtask

    task automatic send_frame(input int port, input int frame, input int n);
        fork
            drive_hdr(port, make_hdr(port, frame));
            drive_beats(port, frame, n);
        join
    endtask

    // transfers are seen at the falling edge before they happen
    task automatic collect();
        forever begin
            @(negedge clk);
            if (out_hdr_valid && out_hdr_ready) got_hdr_q.push_back(out_hdr);
            if (out_beat_valid && out_beat_ready) got_beat_q.push_back(out_beat);
        end
    endtask

    task automatic wait_outputs();
        while (got_hdr_q.size() < exp_hdr_q.size() ||
               got_beat_q.size() < exp_beat_q.size()) @(posedge clk);
        @(posedge clk);
        #2;
    endtask

    task automatic write_cfg(input cfg_addr_e addr, input logic [7:0] data);
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #2;
        cfg_write = 1'b0;
    endtask

    task automatic read_cfg(input cfg_addr_e addr, output logic [7:0] data);
        cfg_read = 1'b1;
        cfg_addr = addr;
        @(posedge clk);
        #2;
        cfg_read = 1'b0;
        if (!cfg_rvalid) begin
            $display("config read gave no rvalid one cycle after the strobe");
            err_count++;
        end
        data = cfg_rdata;
    endtask

    task automatic fetch_cfg(output arb_cfg_t got);
        logic [7:0] mode_data;
        logic [7:0] en_data;
        read_cfg(CFG_MODE, mode_data);
        read_cfg(CFG_ENABLE, en_data);
        got.mode        = arb_mode_e'(mode_data[0]);
        got.port_enable = en_data[N_PORTS-1:0];
    endtask

    task automatic check_hdr(input string name, input eth_hdr_t exp, input eth_hdr_t got);
        check_count++;
        if (got !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, got);
            err_count++;
        end
    endtask

    task automatic check_beat(input string name, input eth_beat_t exp, input eth_beat_t got);
        check_count++;
        if (got !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, got);
            err_count++;
        end
    endtask

    task automatic check_cfg(input string name, input arb_cfg_t exp, input arb_cfg_t got);
        check_count++;
        if (got !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, got);
            err_count++;
        end
    endtask

    task automatic compare_outputs(input string test_name);
        check_count++;
        if (got_hdr_q.size() != exp_hdr_q.size() || got_beat_q.size() != exp_beat_q.size()) begin
            $display("%s: got %0d headers and %0d beats, wanted %0d and %0d", test_name,
                     got_hdr_q.size(), got_beat_q.size(), exp_hdr_q.size(), exp_beat_q.size());
            err_count++;
        end
        for (int i = 0; i < exp_hdr_q.size() && i < got_hdr_q.size(); i++) begin
            check_hdr($sformatf("out_hdr[%0d]", i), exp_hdr_q[i], got_hdr_q[i]);
        end
        for (int i = 0; i < exp_beat_q.size() && i < got_beat_q.size(); i++) begin
            check_beat($sformatf("out_beat[%0d]", i), exp_beat_q[i], got_beat_q[i]);
        end
        exp_hdr_q.delete();
        got_hdr_q.delete();
        exp_beat_q.delete();
        got_beat_q.delete();
        $display("test %s finished, %0d errors so far", test_name, err_count);
    endtask

    task automatic single_frame();
        arb_cfg_t exp_cfg;
        arb_cfg_t got_cfg;
        if (out_hdr_valid || out_beat_valid || |in_hdr_ready || |in_beat_ready || cfg_rvalid) begin
            $display("a valid or ready output was high right after reset");
            err_count++;
        end
        exp_cfg.mode        = ARB_PRIORITY;
        exp_cfg.port_enable = '1;
        fetch_cfg(got_cfg);
        check_cfg("cfg", exp_cfg, got_cfg);
        expect_frame(2, 0, 4);
        send_frame(2, 0, 4);
        wait_outputs();
        compare_outputs("single_frame");
    endtask

    task automatic priority_order();
        for (int p = 0; p < N_PORTS; p++) expect_frame(p, 1, 3);
        fork
            send_frame(0, 1, 3);
            send_frame(1, 1, 3);
            send_frame(2, 1, 3);
            send_frame(3, 1, 3);
        join
        wait_outputs();
        compare_outputs("priority_order");
    endtask

    // last grant was port 3, so the rotation wraps to port 0 first
    task automatic round_robin();
        write_cfg(CFG_MODE, 8'(ARB_ROUND_ROBIN));
        expect_frame(0, 2, 3);
        expect_frame(1, 2, 3);
        expect_frame(2, 2, 3);
        expect_frame(3, 2, 3);
        expect_frame(0, 3, 3);
        fork
            begin
                send_frame(0, 2, 3);
                send_frame(0, 3, 3);
            end
            send_frame(1, 2, 3);
            send_frame(2, 2, 3);
            send_frame(3, 2, 3);
        join
        wait_outputs();
        compare_outputs("round_robin");
    endtask

    task automatic config_mask();
        arb_cfg_t exp_cfg;
        arb_cfg_t got_cfg;
        write_cfg(CFG_ENABLE, 8'b0000_1010);
        fetch_cfg(got_cfg);
        exp_cfg.mode        = ARB_ROUND_ROBIN;
        exp_cfg.port_enable = 4'b1010;
        check_cfg("cfg", exp_cfg, got_cfg);
        in_hdr[0]  = make_hdr(0, 4);
        in_hdr[2]  = make_hdr(2, 4);
        in_beat[0] = make_beat(0, 4, 0, 1);
        in_beat[2] = make_beat(2, 4, 0, 1);
        in_hdr_valid   = in_hdr_valid | 4'b0101;   // offered on disabled ports
        in_beat_valid  = in_beat_valid | 4'b0101;
        watch_disabled = 1'b1;
        expect_frame(1, 4, 4);
        expect_frame(3, 4, 4);
        fork
            send_frame(1, 4, 4);
            send_frame(3, 4, 4);
        join
        wait_outputs();
        repeat (10) @(posedge clk);
        #2;
        watch_disabled = 1'b0;
        in_hdr_valid   = in_hdr_valid & 4'b1010;
        in_beat_valid  = in_beat_valid & 4'b1010;
        write_cfg(CFG_ENABLE, 8'h0f);
        compare_outputs("config_mask");
    endtask

    task automatic back_pressure();
        write_cfg(CFG_MODE, 8'(ARB_PRIORITY));
        bp_enable = 1'b1;
        expect_frame(1, 5, 16);
        expect_frame(2, 5, 16);
        fork
            send_frame(2, 5, 16);
            send_frame(1, 5, 16);
        join
        wait_outputs();
        bp_enable = 1'b0;
        compare_outputs("back_pressure");
    endtask

    always @(negedge clk) begin
        if (watch_disabled && |((in_hdr_ready | in_beat_ready) & 4'b0101)) begin
            $display("a disabled port (0 or 2) saw its ready high");
            err_count++;
        end
    end

    initial begin : backpressure
        out_hdr_ready  = 1'b1;
        out_beat_ready = 1'b1;
        void'($urandom(81));             // seed once for the run
        forever begin
            @(posedge clk);
            #2;
            if (bp_enable) begin
                out_hdr_ready  = ($urandom % 3) != 0;
                out_beat_ready = ($urandom % 2) != 0;
            end else begin
                out_hdr_ready  = 1'b1;
                out_beat_ready = 1'b1;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : main
        in_hdr_valid  = '0;
        in_hdr        = '0;
        in_beat_valid = '0;
        in_beat       = '0;
        cfg_write     = 1'b0;
        cfg_read      = 1'b0;
        cfg_addr      = CFG_MODE;
        cfg_wdata     = '0;
        reset         = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        fork
            collect();
        join_none
        single_frame();
        priority_order();
        round_robin();
        config_mask();
        back_pressure();
        err_count += dut0.asserts0.error_count;
        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
src/eth_arb_pkg.sv
src/arbiter.sv
src/eth_mux_64_4.sv
src/eth_arb_cfg.sv
src/eth_arb_mux_64_4.sv
src/eth_arb_mux_top.sv
dv/eth_arb_mux_asserts.sv
dv/eth_arb_mux_tb.sv

/* src/arbiter.sv */
////////////////////////////////////////////////////////////
// request/grant arbiter, fixed priority or round robin,
// grant is held until the granted port acknowledges
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module arbiter import eth_arb_pkg::*; #(
    parameter int PORTS = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  arb_mode_e                mode,
    input  logic [PORTS-1:0]         request,
    input  logic [PORTS-1:0]         acknowledge,
    output logic [PORTS-1:0]         grant,
    output logic                     grant_valid,
    output logic [$clog2(PORTS)-1:0] grant_encoded
);

    localparam int IDX_W = $clog2(PORTS);

    logic [PORTS-1:0] rr_request;        // requests above the last grant
    logic [PORTS-1:0] search;            // set the pick is made from
    logic [IDX_W-1:0] next_idx;

    assign grant_valid = |grant;

    // grant_encoded keeps the last granted port after release,
    // which is what the round-robin mask rotates from
    always_comb begin
        rr_request = '0;
        for (int i = 0; i < PORTS; i++) begin
            if (i > int'(grant_encoded)) begin
                rr_request[i] = request[i];
            end
        end

        if (mode == ARB_ROUND_ROBIN && |rr_request) begin
            search = rr_request;
        end else begin
            search = request;            // priority, or rr wrap-around
        end

        next_idx = '0;
        for (int i = PORTS - 1; i >= 0; i--) begin
            if (search[i]) begin
                next_idx = IDX_W'(i);    // lowest set bit wins
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            grant         <= '0;
            grant_encoded <= IDX_W'(PORTS - 1);  // first rr pick starts at port 0
        end else if (grant_valid) begin
            if (|(grant & acknowledge)) begin
                grant <= '0;             // release, decide again next cycle
            end
        end else if (|request) begin
            grant         <= PORTS'(1) << next_idx;
            grant_encoded <= next_idx;
        end
    end

endmodule

/* src/eth_arb_cfg.sv */
////////////////////////////////////////////////////////////
// config registers for the arbitrated mux: mode and port
// enable mask, written and read through simple strobes
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module eth_arb_cfg import eth_arb_pkg::*; #(
    parameter arb_mode_e RESET_MODE = ARB_PRIORITY
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      cfg_write,
    input  logic      cfg_read,
    input  cfg_addr_e cfg_addr,
    input  logic [7:0] cfg_wdata,
    output logic [7:0] cfg_rdata,
    output logic      cfg_rvalid,
    output arb_cfg_t  cfg
);

    // register writes
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg.mode        <= RESET_MODE;
            cfg.port_enable <= '1;        // all ports on
        end else if (cfg_write) begin
            case (cfg_addr)
                CFG_MODE:   cfg.mode        <= arb_mode_e'(cfg_wdata[0]);
                CFG_ENABLE: cfg.port_enable <= cfg_wdata[N_PORTS-1:0];
                default:    ;             // unmapped, ignored
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_rvalid <= 1'b0;
        end else begin
            cfg_rvalid <= cfg_read;
        end
    end

    // read data, zero for unmapped addresses
    always_ff @(posedge clk) begin
        if (cfg_read) begin
            case (cfg_addr)
                CFG_MODE:   cfg_rdata <= {7'b0, cfg.mode};
                CFG_ENABLE: cfg_rdata <= {{(8 - N_PORTS){1'b0}}, cfg.port_enable};
                default:    cfg_rdata <= '0;
            endcase
        end
    end

endmodule

/* src/eth_arb_mux_64_4.sv */
////////////////////////////////////////////////////////////
// arbitrated 4-port ethernet mux: one arbiter grant per
// frame, released by the tlast beat of the granted input
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module eth_arb_mux_64_4 import eth_arb_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  arb_cfg_t                cfg,

    input  logic [N_PORTS-1:0]      in_hdr_valid,
    output logic [N_PORTS-1:0]      in_hdr_ready,
    input  eth_hdr_t [N_PORTS-1:0]  in_hdr,

    input  logic [N_PORTS-1:0]      in_beat_valid,
    output logic [N_PORTS-1:0]      in_beat_ready,
    input  eth_beat_t [N_PORTS-1:0] in_beat,

    output logic                    out_hdr_valid,
    input  logic                    out_hdr_ready,
    output eth_hdr_t                out_hdr,

    output logic                    out_beat_valid,
    input  logic                    out_beat_ready,
    output eth_beat_t               out_beat
);

    localparam int SEL_W = $clog2(N_PORTS);

    logic [N_PORTS-1:0] request;
    logic [N_PORTS-1:0] acknowledge;
    logic [N_PORTS-1:0] grant;
    logic [SEL_W-1:0]   grant_encoded;

    // disabled ports never request, an open grant still finishes
    assign request = in_hdr_valid & cfg.port_enable;

    always_comb begin
        for (int i = 0; i < N_PORTS; i++) begin
            acknowledge[i] = in_beat_valid[i] & in_beat_ready[i] & in_beat[i].tlast;
        end
    end

    arbiter #(
        .PORTS(N_PORTS)
    ) arb0 (
        .clk           (clk),
        .reset         (reset),
        .mode          (cfg.mode),
        .request       (request),
        .acknowledge   (acknowledge),
        .grant         (grant),
        .grant_valid   (),
        .grant_encoded (grant_encoded)
    );

    eth_mux_64_4 mux0 (
        .clk            (clk),
        .reset          (reset),
        .select         (grant_encoded),
        .in_hdr_valid   (in_hdr_valid & grant),   // hide ungranted inputs
        .in_hdr_ready   (in_hdr_ready),
        .in_hdr         (in_hdr),
        .in_beat_valid  (in_beat_valid & grant),
        .in_beat_ready  (in_beat_ready),
        .in_beat        (in_beat),
        .out_hdr_valid  (out_hdr_valid),
        .out_hdr_ready  (out_hdr_ready),
        .out_hdr        (out_hdr),
        .out_beat_valid (out_beat_valid),
        .out_beat_ready (out_beat_ready),
        .out_beat       (out_beat)
    );

endmodule

/* src/eth_arb_mux_top.sv */
////////////////////////////////////////////////////////////
// top level: config registers steering the arbitrated mux
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module eth_arb_mux_top import eth_arb_pkg::*; #(
    parameter arb_mode_e RESET_MODE = ARB_PRIORITY
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic [N_PORTS-1:0]      in_hdr_valid,
    output logic [N_PORTS-1:0]      in_hdr_ready,
    input  eth_hdr_t [N_PORTS-1:0]  in_hdr,

    input  logic [N_PORTS-1:0]      in_beat_valid,
    output logic [N_PORTS-1:0]      in_beat_ready,
    input  eth_beat_t [N_PORTS-1:0] in_beat,

    output logic                    out_hdr_valid,
    input  logic                    out_hdr_ready,
    output eth_hdr_t                out_hdr,

    output logic                    out_beat_valid,
    input  logic                    out_beat_ready,
    output eth_beat_t               out_beat,

    input  logic                    cfg_write,
    input  logic                    cfg_read,
    input  cfg_addr_e               cfg_addr,
    input  logic [7:0]              cfg_wdata,
    output logic [7:0]              cfg_rdata,
    output logic                    cfg_rvalid
);

    arb_cfg_t cfg;                       // mode and enable mask

    eth_arb_cfg #(
        .RESET_MODE(RESET_MODE)
    ) cfg0 (
        .clk        (clk),
        .reset      (reset),
        .cfg_write  (cfg_write),
        .cfg_read   (cfg_read),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .cfg_rvalid (cfg_rvalid),
        .cfg        (cfg)
    );

    eth_arb_mux_64_4 arb_mux0 (
        .clk            (clk),
        .reset          (reset),
        .cfg            (cfg),
        .in_hdr_valid   (in_hdr_valid),
        .in_hdr_ready   (in_hdr_ready),
        .in_hdr         (in_hdr),
        .in_beat_valid  (in_beat_valid),
        .in_beat_ready  (in_beat_ready),
        .in_beat        (in_beat),
        .out_hdr_valid  (out_hdr_valid),
        .out_hdr_ready  (out_hdr_ready),
        .out_hdr        (out_hdr),
        .out_beat_valid (out_beat_valid),
        .out_beat_ready (out_beat_ready),
        .out_beat       (out_beat)
    );

endmodule

/* src/eth_arb_pkg.sv */
////////////////////////////////////////////////////////////
// shared types for the 4-port ethernet arbitrated mux:
// header and payload beats, arbiter mode, config registers
////////////////////////////////////////////////////////////

package eth_arb_pkg;

    localparam int N_PORTS = 4;          // mux is fixed at four inputs

    // ethernet header as presented on each input
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // one 64-bit payload beat
    typedef struct packed {
        logic [63:0] tdata;
        logic [7:0]  tkeep;              // byte enables
        logic        tlast;              // end of frame
        logic        tuser;              // frame error flag
    } eth_beat_t;

    typedef enum logic {
        ARB_PRIORITY    = 1'b0,          // lowest index wins
        ARB_ROUND_ROBIN = 1'b1           // search starts after last grant
    } arb_mode_e;

    typedef struct packed {
        arb_mode_e          mode;
        logic [N_PORTS-1:0] port_enable;
    } arb_cfg_t;

    // register map of the config port
    typedef enum logic [1:0] {
        CFG_MODE   = 2'd0,
        CFG_ENABLE = 2'd1
    } cfg_addr_e;

endpackage

/* src/eth_mux_64_4.sv */
////////////////////////////////////////////////////////////
// 4-to-1 ethernet frame mux, header and payload registered;
// select must stay put from header until tlast
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module eth_mux_64_4 import eth_arb_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [$clog2(N_PORTS)-1:0]   select,

    input  logic [N_PORTS-1:0]           in_hdr_valid,
    output logic [N_PORTS-1:0]           in_hdr_ready,
    input  eth_hdr_t [N_PORTS-1:0]       in_hdr,

    input  logic [N_PORTS-1:0]           in_beat_valid,
    output logic [N_PORTS-1:0]           in_beat_ready,
    input  eth_beat_t [N_PORTS-1:0]      in_beat,

    output logic                         out_hdr_valid,
    input  logic                         out_hdr_ready,
    output eth_hdr_t                     out_hdr,

    output logic                         out_beat_valid,
    input  logic                         out_beat_ready,
    output eth_beat_t                    out_beat
);

    localparam int SEL_W = $clog2(N_PORTS);

    logic [SEL_W-1:0] frame_sel;         // input owning the open frame
    logic             frame_open;
    logic             hdr_room;
    logic             hdr_xfer;
    logic             beat_room;
    logic             beat_xfer;
    eth_beat_t        sel_beat;

    // header slot free and no payload still in flight
    assign hdr_room = (~out_hdr_valid | out_hdr_ready) & ~frame_open;
    assign hdr_xfer = hdr_room & in_hdr_valid[select];

    assign beat_room = ~out_beat_valid | out_beat_ready;
    assign sel_beat  = in_beat[frame_sel];
    assign beat_xfer = frame_open & beat_room & in_beat_valid[frame_sel];

    // only one input ever sees ready
    always_comb begin
        in_hdr_ready  = '0;
        in_beat_ready = '0;
        in_hdr_ready[select]     = hdr_room & in_hdr_valid[select];
        in_beat_ready[frame_sel] = frame_open & beat_room;
    end

    // header register and frame tracking
    always_ff @(posedge clk) begin
        if (reset) begin
            out_hdr_valid <= 1'b0;
            frame_open    <= 1'b0;
            frame_sel     <= '0;
        end else begin
            if (out_hdr_ready) begin
                out_hdr_valid <= 1'b0;   // consumed
            end
            if (hdr_xfer) begin
                out_hdr_valid <= 1'b1;
                frame_open    <= 1'b1;
                frame_sel     <= select;
            end else if (beat_xfer && sel_beat.tlast) begin
                frame_open <= 1'b0;      // frame done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_xfer) begin
            out_hdr <= in_hdr[select];
        end
    end

    // one-entry payload register
    always_ff @(posedge clk) begin
        if (reset) begin
            out_beat_valid <= 1'b0;
        end else if (beat_room) begin
            out_beat_valid <= beat_xfer;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_xfer) begin
            out_beat <= sel_beat;        // holds while stalled
        end
    end

endmodule
